//--- Makefile
# Verilator build and run for the Multiface Two block

VERILATOR ?= verilator
TOP       ?= mf2_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/mf2_props.sv
/*
 * Multiface Two bus properties
 * Overlay selects stay exclusive and inside their window, and a fetch
 * at the NMI vector clears the NMI
 */
`timescale 1ns/10ps

module mf2_props (
	input logic        clk_sys,
	input logic        reset,
	input logic        m1,
	input logic [15:0] cpu_addr,
	input logic        nmi,
	input logic        rom_sel,
	input logic        ram_sel
);

	int unsigned fail_count = 0; // Read by the testbench at the end

	sel_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_sel && ram_sel))
		else begin
			$error("ROM and RAM overlays selected together");
			fail_count++;
		end

	rom_in_window: assert property (@(posedge clk_sys) disable iff (reset)
		rom_sel |-> (cpu_addr[15:13] == mf2_pkg::ROM_WINDOW))
		else begin
			$error("ROM overlay selected outside its window");
			fail_count++;
		end

	// Entry through the vector drops the request
	nmi_taken: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(m1) && nmi && cpu_addr == mf2_pkg::NMI_VECTOR) |=> !nmi)
		else begin
			$error("NMI still high after a fetch at the NMI vector");
			fail_count++;
		end

endmodule

//--- dv/mf2_tb.sv
/*
 * Multiface Two testbench
 * Walks the CPU bus through NMI entry, register shadowing, RAM access,
 * paging and hiding, and compares against a reference shadow map
 */
`timescale 1ns/10ps

module mf2_tb;

	logic        clk_sys;
	logic        reset;
	logic        rst_req;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        io_wr;
	logic        mem_rd;
	logic        mem_wr;
	logic        m1;
	logic        key_nmi;
	logic [1:0]  mf2_mode;
	logic        nmi;
	logic        rom_sel;
	logic        ram_sel;
	logic [7:0]  cpu_din;

	int          seed;
	int          checks;
	int          errors;
	int          timeouts;
	int unsigned prop_fails;
	logic [4:0]  ref_pen;  // Last pen seen by the model
	logic [3:0]  ref_crtc;
	logic [7:0]  ref_mem [0:8191];
	logic [12:0] touched[$];

	// Pending comparisons
	string       name_q[$];
	logic [7:0]  got_q[$];
	logic [7:0]  exp_q[$];
	time         time_q[$];

	tb_clock_gen u_clk (.rst_req(rst_req), .clk_sys(clk_sys), .reset(reset));

	mf2_top u_mf2_top (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.io_wr   (io_wr),
		.mem_rd  (mem_rd),
		.mem_wr  (mem_wr),
		.m1      (m1),
		.key_nmi (key_nmi),
		.mf2_mode(mf2_mode),
		.nmi     (nmi),
		.rom_sel (rom_sel),
		.ram_sel (ram_sel),
		.cpu_din (cpu_din)
	);

	bind mf2_top mf2_props u_props (.clk_sys(clk_sys), .reset(reset), .m1(m1),
		.cpu_addr(cpu_addr), .nmi(nmi), .rom_sel(rom_sel), .ram_sel(ram_sel));

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// Cell for a port write, keeps its own pen and CRTC register
	function automatic logic [12:0] shadow_offset(input logic [7:0] port,
			input logic [7:0] data);
		mf2_pkg::ga_word_u w;
		logic [12:0]       off;
		w.raw = data;
		off   = 13'h0000;
		case (port)
			mf2_pkg::PORT_GA: begin
				case (w.cmd.func)
					2'b00: begin
						off     = mf2_pkg::SH_PEN_INDEX;
						ref_pen = w.cmd.payload[4:0];
					end
					2'b01: off = (ref_pen >= 5'd16) ? mf2_pkg::SH_BORDER
						: mf2_pkg::SH_PEN_BASE + {9'd0, ref_pen[3:0]};
					2'b10: off = mf2_pkg::SH_MODE;
					default: off = mf2_pkg::SH_BANK;
				endcase
			end
			mf2_pkg::PORT_CRTC_SEL: begin
				off      = mf2_pkg::SH_CRTC_SEL;
				ref_crtc = data[3:0];
			end
			mf2_pkg::PORT_CRTC_VAL: off = mf2_pkg::SH_CRTC_BASE + {9'd0, ref_crtc};
			mf2_pkg::PORT_PPI:      off = mf2_pkg::SH_PPI;
			mf2_pkg::PORT_ROMSEL:   off = mf2_pkg::SH_ROMSEL;
			default:                off = 13'h0000;
		endcase
		return off;
	endfunction

	////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////

	task automatic cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1; // Inputs move 1 ns after the edge
	endtask

	task automatic expect_eq(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
		time_q.push_back($time);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		io_wr    = 1'b1;
		cycles(3);
		io_wr    = 1'b0;
		cycles(2);
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		mem_wr   = 1'b1;
		cycles(3);
		mem_wr   = 1'b0;
		cycles(2);
	endtask

	// Data is valid on the second edge after mem_rd rises
	task automatic read_mem(input logic [15:0] addr, output logic [7:0] data);
		cpu_addr = addr;
		mem_rd   = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		data = cpu_din;
		cycles(1);
		mem_rd = 1'b0;
		cycles(2);
	endtask

	task automatic fetch(input logic [15:0] addr);
		cpu_addr = addr;
		m1       = 1'b1;
		cycles(3);
		m1       = 1'b0;
		cycles(2);
	endtask

	task automatic press_nmi();
		key_nmi = 1'b1;
		cycles(3);
		key_nmi = 1'b0;
		cycles(2);
	endtask

	task automatic shadow_write(input logic [7:0] port, input logic [7:0] data);
		logic [12:0] off;
		logic [31:0] r;
		off = shadow_offset(port, data);
		ref_mem[off] = data;
		touched.push_back(off);
		r = rand32();
		io_write({port, r[7:0]}, data); // Low address byte is don't care
	endtask

	task automatic check_selects(input logic [15:0] addr, input logic rom,
			input logic ram);
		cpu_addr = addr;
		@(negedge clk_sys);
		expect_eq("rom_sel", {7'd0, rom_sel}, {7'd0, rom});
		expect_eq("ram_sel", {7'd0, ram_sel}, {7'd0, ram});
		cycles(1);
	endtask

	task automatic check_read(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		read_mem(addr, got);
		expect_eq("cpu_din", got, exp);
	endtask

	task automatic sample_nmi(input logic exp);
		@(negedge clk_sys);
		expect_eq("nmi", {7'd0, nmi}, {7'd0, exp});
		cycles(1);
	endtask

	task automatic wait_nmi(input logic level);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (nmi !== level && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (nmi !== level) begin
			timeouts++;
			$display("Timeout while waiting for nmi to become %0b", level);
		end
		cycles(1);
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (reset !== 1'b0 && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (reset !== 1'b0) begin
			timeouts++;
			$display("Timeout while waiting for reset to be released");
		end
		cycles(1);
	endtask

	task automatic apply_reset(input logic [1:0] mode);
		mf2_mode = mode; // Sampled while reset is high
		rst_req  = 1'b1;
		cycles(1);
		rst_req  = 1'b0;
		wait_reset();
	endtask

	////////////////////////////////////////////////////////////
	// Comparing process
	////////////////////////////////////////////////////////////

	task automatic compare_next();
		string      name;
		logic [7:0] got;
		logic [7:0] exp;
		time        t;
		name = name_q.pop_front();
		got  = got_q.pop_front();
		exp  = exp_q.pop_front();
		t    = time_q.pop_front();
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("[ERROR] %0d ns %s: got %02h, expected %02h", t, name, got, exp);
		end
	endtask

	always @(posedge clk_sys) begin
		while (exp_q.size() != 0)
			compare_next();
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [7:0]  sel;
		logic [15:0] a;
		logic [15:0] ram_addrs[$];

		seed     = 32'hdd68;
		checks   = 0;
		errors   = 0;
		timeouts = 0;
		ref_pen  = '0;
		ref_crtc = '0;
		rst_req  = 1'b0;
		cpu_addr = '0;
		cpu_dout = '0;
		io_wr    = 1'b0;
		mem_rd   = 1'b0;
		mem_wr   = 1'b0;
		m1       = 1'b0;
		key_nmi  = 1'b0;
		mf2_mode = mf2_pkg::MODE_ENABLED;
		wait_reset();

		// After reset, nothing selected and the bus floats high
		sample_nmi(1'b0);
		check_selects(16'h0000, 1'b0, 1'b0);
		check_selects(16'h2000, 1'b0, 1'b0);
		check_read(16'h0000, 8'hFF);
		check_read(16'h2000, 8'hFF);
		r = rand32();
		check_read(r[15:0], 8'hFF);

		// NMI and entry
		press_nmi();
		wait_nmi(1'b1);
		fetch(mf2_pkg::NMI_VECTOR);
		wait_nmi(1'b0);
		check_selects(16'h1234, 1'b1, 1'b0);
		check_selects(16'h2345, 1'b0, 1'b1);
		check_selects(16'h4000, 1'b0, 1'b0);

		// Pen sequence past 15 reaches the border cell
		for (int i = 0; i < 18; i++) begin
			r = rand32();
			shadow_write(mf2_pkg::PORT_GA, {3'b000, i[4:0]});
			shadow_write(mf2_pkg::PORT_GA, {3'b010, r[4:0]});
		end
		for (int i = 0; i < 16; i++) begin
			r = rand32();
			shadow_write(mf2_pkg::PORT_CRTC_SEL, {4'h0, i[3:0]});
			shadow_write(mf2_pkg::PORT_CRTC_VAL, r[7:0]);
		end
		for (int i = 0; i < 40; i++) begin
			r   = rand32();
			sel = r[15:8] % 8'd5;
			case (sel)
				8'd0:    shadow_write(mf2_pkg::PORT_GA, r[7:0]);
				8'd1:    shadow_write(mf2_pkg::PORT_CRTC_SEL, r[7:0]);
				8'd2:    shadow_write(mf2_pkg::PORT_CRTC_VAL, r[7:0]);
				8'd3:    shadow_write(mf2_pkg::PORT_PPI, r[7:0]);
				default: shadow_write(mf2_pkg::PORT_ROMSEL, r[7:0]);
			endcase
		end
		foreach (touched[i])
			check_read(16'h2000 + {3'b000, touched[i]}, ref_mem[touched[i]]);

		// CPU access to the RAM window
		for (int i = 0; i < 40; i++) begin
			r = rand32();
			a = 16'h2000 + {3'b000, r[12:0]};
			ref_mem[a[12:0]] = r[23:16];
			ram_addrs.push_back(a);
			mem_write(a, r[23:16]);
		end
		foreach (ram_addrs[i])
			check_read(ram_addrs[i], ref_mem[ram_addrs[i][12:0]]);

		// Paged out, the window is gone
		io_write(16'hFEEA, 8'h00);
		check_selects(16'h2000, 1'b0, 1'b0);
		check_read(ram_addrs[0], 8'hFF);

		// Paging back in, then hiding
		io_write(16'hFEE8, 8'h00);
		check_selects(16'h2000, 1'b0, 1'b1);
		check_read(ram_addrs[0], ref_mem[ram_addrs[0][12:0]]);
		fetch(mf2_pkg::HIDE_VECTOR);
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);
		check_selects(16'h0000, 1'b0, 1'b0);
		check_selects(16'h2000, 1'b0, 1'b0);

		// Disabled mode ignores the button
		apply_reset(mf2_pkg::MODE_DISABLED);
		press_nmi();
		cycles(2);
		sample_nmi(1'b0);

		// Hidden from reset until the next entry
		apply_reset(mf2_pkg::MODE_HIDDEN);
		io_write(16'hFEE8, 8'h00);
		check_selects(16'h2000, 1'b0, 1'b0);
		press_nmi();
		wait_nmi(1'b1);
		fetch(mf2_pkg::NMI_VECTOR);
		wait_nmi(1'b0);
		check_selects(16'h2000, 1'b0, 1'b1);
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);
		check_selects(16'h2000, 1'b0, 1'b1);

		cycles(2); // Drain pending comparisons
		prop_fails = u_mf2_top.u_props.fail_count;
		$display("Checks %0d, errors %0d, timeouts %0d, property failures %0d",
			checks, errors, timeouts, prop_fails);
		if (errors == 0 && timeouts == 0 && prop_fails == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- dv/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 10 ns clk_sys, reset held for 5 cycles at start and on each request
 */
`timescale 1ns/10ps

module tb_clock_gen (
	input  logic rst_req,
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Released 1 ns after the fifth rising edge
	initial begin
		reset = 1'b1;
		forever begin
			repeat (5) @(posedge clk_sys);
			#1 reset = 1'b0;
			@(posedge rst_req);
			reset = 1'b1; // Request already arrives 1 ns after an edge
		end
	end

endmodule

//--- filelist.f
source/mf2_pkg.sv
source/mf2_control.sv
source/mf2_io_snoop.sv
source/mf2_shadow_ram.sv
source/mf2_top.sv
dv/tb_clock_gen.sv
dv/mf2_props.sv
dv/mf2_tb.sv

//--- source/mf2_control.sv
/*
 * Multiface Two control
 * NMI button handling, paging and hiding state, and the ROM and RAM
 * overlay window selects
 */
`timescale 1ns/10ps

module mf2_control (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        key_nmi,
	input  logic        m1,
	input  logic [15:0] cpu_addr,
	input  logic [1:0]  mf2_mode,
	input  logic        page_wr,
	input  logic        page_off,
	output logic        nmi,
	output logic        rom_sel,
	output logic        ram_sel
);

	logic mf2_en;
	logic hidden;
	logic key_nmi_q;
	logic m1_q;
	logic key_rise;
	logic fetch;

	assign key_rise = key_nmi & ~key_nmi_q;
	assign fetch    = m1 & ~m1_q; // Opcode fetch starts

	////////////////////////////////////////////////////////////
	// Strobe history
	////////////////////////////////////////////////////////////

	// Tracks through reset so a held button gives no edge after it
	always_ff @(posedge clk_sys) begin
		key_nmi_q <= key_nmi;
		m1_q      <= m1;
	end

	////////////////////////////////////////////////////////////
	// NMI, paging and hiding
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mf2_en <= 1'b0;
			hidden <= (mf2_mode != mf2_pkg::MODE_ENABLED);
			nmi    <= 1'b0;
		end else begin
			if (key_rise && !mf2_en && mf2_mode != mf2_pkg::MODE_DISABLED)
				nmi <= 1'b1;

			// Entry through the NMI vector
			if (nmi && fetch && cpu_addr == mf2_pkg::NMI_VECTOR) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (mf2_en && fetch && cpu_addr == mf2_pkg::HIDE_VECTOR)
				hidden <= 1'b1; // Software asked to hide

			// Paging port wins over a fetch in the same cycle
			if (page_wr)
				mf2_en <= ~page_off & ~hidden;
		end
	end

	// Overlay windows
	assign rom_sel = mf2_en && (cpu_addr[15:13] == mf2_pkg::ROM_WINDOW);
	assign ram_sel = mf2_en && (cpu_addr[15:13] == mf2_pkg::RAM_WINDOW);

endmodule

//--- source/mf2_io_snoop.sv
/*
 * Multiface Two I/O snoop
 * Watches CPU I/O writes, flags the FEE8/FEEA paging ports and maps
 * hardware register writes onto their shadow RAM cells
 */
`timescale 1ns/10ps

module mf2_io_snoop (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        io_wr,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dout,
	output logic        page_wr,
	output logic        page_off,
	output logic        shadow_we,
	output logic [12:0] shadow_addr,
	output logic [7:0]  shadow_data
);

	logic                io_wr_q;
	logic                io_wr_rise;
	logic                is_page;
	logic [7:0]          port;
	logic [12:0]         sh_offset;
	logic [4:0]          pen_index; // Last pen chosen on the gate array
	logic [3:0]          crtc_reg;  // Last CRTC register selected
	mf2_pkg::ga_word_u   ga_word;

	assign io_wr_rise = io_wr & ~io_wr_q;
	assign port       = cpu_addr[15:8];
	assign is_page    = (cpu_addr[15:2] == mf2_pkg::PAGE_PORT_HI);

	////////////////////////////////////////////////////////////
	// Shadow cell decode
	////////////////////////////////////////////////////////////

	always_comb begin
		ga_word.raw = cpu_dout;
		sh_offset   = '0; // Zero means not shadowed
		case (port)
			mf2_pkg::PORT_GA: begin
				case (ga_word.cmd.func)
					mf2_pkg::GA_FN_PEN:  sh_offset = mf2_pkg::SH_PEN_INDEX;
					mf2_pkg::GA_FN_INK: begin
						// Pen 16 and up is the border
						if (pen_index[4])
							sh_offset = mf2_pkg::SH_BORDER;
						else
							sh_offset = mf2_pkg::SH_PEN_BASE + {9'd0, pen_index[3:0]};
					end
					mf2_pkg::GA_FN_MODE: sh_offset = mf2_pkg::SH_MODE;
					mf2_pkg::GA_FN_BANK: sh_offset = mf2_pkg::SH_BANK;
					default:             sh_offset = '0;
				endcase
			end
			mf2_pkg::PORT_CRTC_SEL: sh_offset = mf2_pkg::SH_CRTC_SEL;
			mf2_pkg::PORT_CRTC_VAL: sh_offset = mf2_pkg::SH_CRTC_BASE + {9'd0, crtc_reg};
			mf2_pkg::PORT_PPI:      sh_offset = mf2_pkg::SH_PPI;
			mf2_pkg::PORT_ROMSEL:   sh_offset = mf2_pkg::SH_ROMSEL;
			default:                sh_offset = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Strobes and register tracking
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		io_wr_q <= io_wr;
		if (reset) begin
			page_wr   <= 1'b0;
			shadow_we <= 1'b0;
			pen_index <= '0;
			crtc_reg  <= '0;
		end else begin
			page_wr   <= io_wr_rise & is_page;
			shadow_we <= io_wr_rise & ~is_page & (sh_offset != '0);
			if (io_wr_rise && !is_page) begin
				if (port == mf2_pkg::PORT_GA && ga_word.cmd.func == mf2_pkg::GA_FN_PEN)
					pen_index <= ga_word.cmd.payload[4:0];
				if (port == mf2_pkg::PORT_CRTC_SEL)
					crtc_reg <= ga_word.raw[3:0];
			end
		end
	end

	// Payload, qualified by the strobes above
	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			page_off    <= cpu_addr[1]; // FEEA pages out
			shadow_addr <= sh_offset;
			shadow_data <= ga_word.raw;
		end
	end

endmodule

//--- source/mf2_pkg.sv
/*
 * Multiface Two shared definitions
 * Port addresses, fetch vectors, the shadow cell map inside the 8 KB RAM,
 * overlay window codes, reset mode codes and the gate array command word
 */
package mf2_pkg;

	////////////////////////////////////////////////////////////
	// Geometry and vectors
	////////////////////////////////////////////////////////////

	localparam int SHADOW_AW = 13; // 8 KB shadow RAM

	localparam logic [15:0] NMI_VECTOR  = 16'h0066; // Fetch here takes the NMI
	localparam logic [15:0] HIDE_VECTOR = 16'h0065;

	// FEE8 pages in, FEEA pages out, bit 1 tells them apart
	localparam logic [13:0] PAGE_PORT_HI = 14'b11111110111010;

	////////////////////////////////////////////////////////////
	// Snooped I/O ports, high address byte
	////////////////////////////////////////////////////////////

	localparam logic [7:0] PORT_GA       = 8'h7F; // Gate array
	localparam logic [7:0] PORT_CRTC_SEL = 8'hBC;
	localparam logic [7:0] PORT_CRTC_VAL = 8'hBD;
	localparam logic [7:0] PORT_PPI      = 8'hF7; // 8255 control
	localparam logic [7:0] PORT_ROMSEL   = 8'hDF; // Upper ROM select

	// Gate array command functions, top two data bits
	localparam logic [1:0] GA_FN_PEN  = 2'b00;
	localparam logic [1:0] GA_FN_INK  = 2'b01;
	localparam logic [1:0] GA_FN_MODE = 2'b10;
	localparam logic [1:0] GA_FN_BANK = 2'b11;

	// Fixed cells in shadow RAM
	localparam logic [12:0] SH_PEN_INDEX = 13'h1FCF;
	localparam logic [12:0] SH_BORDER    = 13'h1FDF;
	localparam logic [12:0] SH_PEN_BASE  = 13'h1F90; // Plus 4-bit pen
	localparam logic [12:0] SH_MODE      = 13'h1FEF;
	localparam logic [12:0] SH_BANK      = 13'h1FFF;
	localparam logic [12:0] SH_CRTC_SEL  = 13'h1CFF;
	localparam logic [12:0] SH_CRTC_BASE = 13'h1DB0; // Plus 4-bit register
	localparam logic [12:0] SH_PPI       = 13'h17FF;
	localparam logic [12:0] SH_ROMSEL    = 13'h1AAC;

	// Overlay windows, top three address bits
	localparam logic [2:0] ROM_WINDOW = 3'b000;
	localparam logic [2:0] RAM_WINDOW = 3'b001;

	// Reset modes
	localparam logic [1:0] MODE_ENABLED  = 2'd0;
	localparam logic [1:0] MODE_HIDDEN   = 2'd1;
	localparam logic [1:0] MODE_DISABLED = 2'd2;

	// Gate array command view of a data byte
	typedef struct packed {
		logic [1:0] func;
		logic [5:0] payload; // Low 5 bits hold pen or colour
	} ga_cmd_t;

	typedef union packed {
		logic [7:0] raw;
		ga_cmd_t    cmd;
	} ga_word_u;

endpackage

//--- source/mf2_shadow_ram.sv
/*
 * Multiface Two RAM
 * 8 KB array shared by shadow captures and CPU accesses, with
 * write-through read data and bus gating of cpu_din
 */
`timescale 1ns/10ps

module mf2_shadow_ram (
	input  logic                         clk_sys,
	input  logic                         shadow_we,
	input  logic [mf2_pkg::SHADOW_AW-1:0] shadow_addr,
	input  logic [7:0]                   shadow_data,
	input  logic                         mem_wr,
	input  logic                         mem_rd,
	input  logic                         ram_sel,
	input  logic [mf2_pkg::SHADOW_AW-1:0] cpu_addr,
	input  logic [7:0]                   cpu_dout,
	output logic [7:0]                   cpu_din
);

	logic [7:0]                    mem [0:(1 << mf2_pkg::SHADOW_AW) - 1];
	logic [mf2_pkg::SHADOW_AW-1:0] ram_a;
	logic                          ram_we;
	logic [7:0]                    ram_in;
	logic [7:0]                    ram_out;

	// Address stage, shadow capture first
	always_ff @(posedge clk_sys) begin
		if (shadow_we) begin
			ram_a  <= shadow_addr;
			ram_in <= shadow_data;
			ram_we <= 1'b1;
		end else if (mem_wr && ram_sel) begin
			ram_a  <= cpu_addr;
			ram_in <= cpu_dout;
			ram_we <= 1'b1;
		end else begin
			ram_a  <= cpu_addr; // Plain read
			ram_we <= 1'b0;
		end
	end

	// Data stage
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			ram_out    <= ram_in; // Write-through
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	// Open bus reads as FF
	assign cpu_din = (mem_rd && ram_sel) ? ram_out : 8'hFF;

endmodule

//--- source/mf2_top.sv
/*
 * Multiface Two top level
 * Joins control, I/O snoop and the shadow RAM to the CPU bus
 */
`timescale 1ns/10ps

module mf2_top (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dout,
	input  logic        io_wr,
	input  logic        mem_rd,
	input  logic        mem_wr,
	input  logic        m1,
	input  logic        key_nmi,
	input  logic [1:0]  mf2_mode,
	output logic        nmi,
	output logic        rom_sel,
	output logic        ram_sel,
	output logic [7:0]  cpu_din
);

	logic                          page_wr;
	logic                          page_off;
	logic                          shadow_we;
	logic [mf2_pkg::SHADOW_AW-1:0] shadow_addr;
	logic [7:0]                    shadow_data;

	mf2_control u_control (
		.clk_sys (clk_sys),
		.reset   (reset),
		.key_nmi (key_nmi),
		.m1      (m1),
		.cpu_addr(cpu_addr),
		.mf2_mode(mf2_mode),
		.page_wr (page_wr),
		.page_off(page_off),
		.nmi     (nmi),
		.rom_sel (rom_sel),
		.ram_sel (ram_sel)
	);

	mf2_io_snoop u_snoop (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_wr      (io_wr),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.page_wr    (page_wr),
		.page_off   (page_off),
		.shadow_we  (shadow_we),
		.shadow_addr(shadow_addr),
		.shadow_data(shadow_data)
	);

	// RAM sees only the low address bits of the window
	mf2_shadow_ram u_ram (
		.clk_sys    (clk_sys),
		.shadow_we  (shadow_we),
		.shadow_addr(shadow_addr),
		.shadow_data(shadow_data),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.ram_sel    (ram_sel),
		.cpu_addr   (cpu_addr[mf2_pkg::SHADOW_AW-1:0]),
		.cpu_dout   (cpu_dout),
		.cpu_din    (cpu_din)
	);

endmodule
